// ==== Makefile ====
# Verilator build and run for the stack engine testbench

VERILATOR ?= verilator
TOP       ?= stack_engine_tb
RTL_TOP   ?= stack_engine_top
FILELIST  ?= build.f
BUILD     ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert

SRCS := $(shell grep -v '^+' $(FILELIST))
SIM  := $(BUILD)/V$(TOP)

.PHONY: all run lint clean

all: run

$(SIM): $(SRCS) $(FILELIST)
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TOP) --Mdir $(BUILD)

run: $(SIM)
	./$(SIM) | tee $(LOG)
	@grep -qx '>>> PASS' $(LOG)

lint:
	$(VERILATOR) --lint-only -Wall --timing -f $(FILELIST) --top-module $(RTL_TOP)

clean:
	rm -rf $(BUILD) $(LOG)

// ==== build.f ====
hw/z80_ctrl_pkg.sv
hw/z80_bus_pkg.sv
hw/apb_cmd_port.sv
hw/cmd_fifo.sv
hw/xpt_sequencer.sv
hw/stack_op_decoder.sv
hw/stack_datapath.sv
hw/stack_engine_top.sv
verif/stack_engine_tb.sv

// ==== hw/apb_cmd_port.sv ====
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// apb slave: command queueing, register access, status
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps

module apb_cmd_port (
    input  logic                          clk,
    input  logic                          rst,
    input  logic                          psel,
    input  logic                          penable,
    input  logic                          pwrite,
    input  logic [4:0]                    paddr,
    input  logic [15:0]                   pwdata,
    input  logic                          full,
    input  logic                          busy,
    input  logic [7:0]                    count,
    input  logic [15:0]                   ix,
    input  logic [15:0]                   iy,
    input  logic [15:0]                   sp,
    output logic [15:0]                   prdata,
    output logic                          pready,
    output logic                          pslverr,
    output logic                          push,
    output logic [z80_bus_pkg::CMD_W-1:0] push_data,
    output logic                          host_wr,
    output logic [4:0]                    host_sel,
    output logic [15:0]                   host_data
);

    logic        access;
    logic        hit_cmd;
    logic        hit_reg;
    logic        hit_stat;
    logic [15:0] status_word;

    assign access   = psel && penable;
    assign hit_cmd  = (paddr == z80_bus_pkg::ADDR_CMD);
    assign hit_stat = (paddr == z80_bus_pkg::ADDR_STATUS);
    assign hit_reg  = (paddr == z80_bus_pkg::ADDR_IX) || (paddr == z80_bus_pkg::ADDR_IY) ||
                      (paddr == z80_bus_pkg::ADDR_SP);

    // wait states: cmd writes on a full fifo, register access while executing
    assign pready  = access && (hit_cmd ? (!pwrite || !full) :
                                hit_reg ? !busy : 1'b1);
    assign pslverr = access && !(hit_cmd || hit_reg || hit_stat);

    assign push      = access && pwrite && hit_cmd && pready; // completing cycle only
    assign push_data = pwdata[z80_bus_pkg::CMD_W-1:0];

    assign host_wr   = access && pwrite && hit_reg && !busy;
    assign host_sel  = paddr;
    assign host_data = pwdata;

    always_comb begin
        status_word = '0;
        status_word[z80_bus_pkg::STAT_CNT_W-1:0] = count;
        status_word[z80_bus_pkg::STAT_BIT_BUSY]  = busy;
    end

    always_comb begin
        prdata = '0;
        if (psel && !pwrite) begin
            case (paddr)
                z80_bus_pkg::ADDR_IX:     prdata = ix;
                z80_bus_pkg::ADDR_IY:     prdata = iy;
                z80_bus_pkg::ADDR_SP:     prdata = sp;
                z80_bus_pkg::ADDR_STATUS: prdata = status_word;
                default:                  prdata = '0; // cmd reads back as zero
            endcase
        end
    end

    // the fifo must never see a push it cannot take
    a_no_push_full: assert property (@(posedge clk) disable iff (rst)
        push |-> !full);

endmodule

// ==== hw/cmd_fifo.sv ====
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// synchronous command fifo with occupancy count
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps

module cmd_fifo #(
    parameter int FIFO_DEPTH = 4
) (
    input  logic                          clk,
    input  logic                          rst,
    input  logic                          push,
    input  logic [z80_bus_pkg::CMD_W-1:0] push_data,
    input  logic                          pop,
    output logic [z80_bus_pkg::CMD_W-1:0] pop_data,
    output logic                          empty,
    output logic                          full,
    output logic [7:0]                    count
);

    localparam int PW = (FIFO_DEPTH > 1) ? $clog2(FIFO_DEPTH) : 1;

    logic [z80_bus_pkg::CMD_W-1:0] mem [FIFO_DEPTH];
    logic [PW-1:0]                 wr_ptr;
    logic [PW-1:0]                 rd_ptr;
    logic                          do_push;
    logic                          do_pop;

    assign empty    = (count == 8'd0);
    assign full     = (count == 8'(FIFO_DEPTH));
    assign do_push  = push && !full;
    assign do_pop   = pop && !empty;
    assign pop_data = mem[rd_ptr]; // first word shows without a read cycle

    always_ff @(posedge clk) begin
        if (do_push) begin
            mem[wr_ptr] <= push_data;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (do_push) begin
                wr_ptr <= (wr_ptr == PW'(FIFO_DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
            end
            if (do_pop) begin
                rd_ptr <= (rd_ptr == PW'(FIFO_DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
            end
            count <= count + 8'(do_push) - 8'(do_pop);
        end
    end

    a_no_pop_empty: assert property (@(posedge clk) disable iff (rst)
        pop |-> !empty);

endmodule

// ==== hw/stack_datapath.sv ====
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// sp, ix, iy registers and byte-wide stack memory
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps

module stack_datapath #(
    parameter int STACK_AW = 8
) (
    input  logic        clk,
    input  logic        rst,
    input  logic        is_y,
    input  logic        sel_sp_addr,
    input  logic        mem_wr,
    input  logic        sp_inc,
    input  logic        sp_dec,
    input  logic        wr_x_low,
    input  logic        wr_x_high,
    input  logic        rd_x_low,
    input  logic        rd_x_high,
    input  logic        host_wr,
    input  logic [4:0]  host_sel,
    input  logic [15:0] host_data,
    output logic [15:0] ix,
    output logic [15:0] iy,
    output logic [15:0] sp
);

    logic [7:0]          stack_mem [2**STACK_AW];
    logic [STACK_AW-1:0] mem_addr;
    logic [7:0]          mem_rdata;
    logic [7:0]          mem_wdata;
    logic [15:0]         x_sel;
    logic [15:0]         x_next;
    logic                mem_we;
    logic                host_ok;
    logic                wr_ix, wr_iy;

    assign mem_addr  = sp[STACK_AW-1:0];
    assign mem_rdata = stack_mem[mem_addr];
    assign x_sel     = is_y ? iy : ix;
    assign mem_wdata = rd_x_high ? x_sel[15:8] : x_sel[7:0];
    assign mem_we    = sel_sp_addr && mem_wr && (rd_x_low || rd_x_high);

    // pop merges the incoming byte into the addressed half
    assign x_next = wr_x_high ? {mem_rdata, x_sel[7:0]} : {x_sel[15:8], mem_rdata};
    assign wr_ix  = sel_sp_addr && (wr_x_low || wr_x_high) && !is_y;
    assign wr_iy  = sel_sp_addr && (wr_x_low || wr_x_high) && is_y;

    assign host_ok = host_wr && !sel_sp_addr; // engine owns the registers during t4..t9

    always_ff @(posedge clk) begin
        if (mem_we) begin
            stack_mem[mem_addr] <= mem_wdata;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            ix <= '0;
            iy <= '0;
            sp <= 16'hFFFF;
        end else begin
            if (sel_sp_addr && sp_inc) begin
                sp <= sp + 16'd1;
            end else if (sel_sp_addr && sp_dec) begin
                sp <= sp - 16'd1;
            end else if (host_ok && host_sel == z80_bus_pkg::ADDR_SP) begin
                sp <= host_data;
            end
            if (wr_ix) begin
                ix <= x_next;
            end else if (host_ok && host_sel == z80_bus_pkg::ADDR_IX) begin
                ix <= host_data;
            end
            if (wr_iy) begin
                iy <= x_next;
            end else if (host_ok && host_sel == z80_bus_pkg::ADDR_IY) begin
                iy <= host_data;
            end
        end
    end

    a_sp_step: assert property (@(posedge clk) disable iff (rst)
        !(sp_inc && sp_dec));

    // every memory write cycle carries exactly one register byte
    a_wr_byte: assert property (@(posedge clk) disable iff (rst)
        mem_wr |-> (rd_x_low ^ rd_x_high));

endmodule

// ==== hw/stack_engine_top.sv ====
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// stack engine: apb port, fifo, sequencer, decoder, datapath
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps

module stack_engine_top #(
    parameter int FIFO_DEPTH = 4,
    parameter int STACK_AW   = 8
) (
    input  logic        clk,
    input  logic        rst,
    input  logic        psel,
    input  logic        penable,
    input  logic        pwrite,
    input  logic [4:0]  paddr,
    input  logic [15:0] pwdata,
    output logic [15:0] prdata,
    output logic        pready,
    output logic        pslverr
);

    logic                           push, pop, full, empty, busy;
    logic [z80_bus_pkg::CMD_W-1:0]  push_data, pop_data;
    logic [7:0]                     count;
    logic [z80_ctrl_pkg::XPT_W-1:0] xpt;
    logic                           enable, is_y, xpt_reset;
    z80_ctrl_pkg::stack_op_e        op;
    logic                           sel_sp_addr, mem_wr, sp_inc, sp_dec;
    logic                           wr_x_low, wr_x_high, rd_x_low, rd_x_high;
    logic                           host_wr;
    logic [4:0]                     host_sel;
    logic [15:0]                    host_data, ix, iy, sp;

    apb_cmd_port u_port (
        .clk, .rst, .psel, .penable, .pwrite, .paddr, .pwdata,
        .full, .busy, .count, .ix, .iy, .sp,
        .prdata, .pready, .pslverr, .push, .push_data,
        .host_wr, .host_sel, .host_data
    );

    cmd_fifo #(.FIFO_DEPTH(FIFO_DEPTH)) u_fifo (
        .clk, .rst, .push, .push_data, .pop, .pop_data, .empty, .full, .count
    );

    xpt_sequencer u_seq (
        .clk, .rst, .empty, .pop_data, .xpt_reset,
        .pop, .xpt, .enable, .op, .is_y, .busy
    );

    stack_op_decoder u_dec (
        .enable, .xpt, .op, .is_y,
        .sel_sp_addr, .mem_wr, .sp_inc, .sp_dec,
        .wr_x_low, .wr_x_high, .rd_x_low, .rd_x_high, .xpt_reset
    );

    stack_datapath #(.STACK_AW(STACK_AW)) u_dp (
        .clk, .rst, .is_y, .sel_sp_addr, .mem_wr, .sp_inc, .sp_dec,
        .wr_x_low, .wr_x_high, .rd_x_low, .rd_x_high,
        .host_wr, .host_sel, .host_data, .ix, .iy, .sp
    );

endmodule

// ==== hw/stack_op_decoder.sv ====
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// xpt decode into push/pop ix/iy strobes
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps

module stack_op_decoder (
    input  logic                           enable,
    input  logic [z80_ctrl_pkg::XPT_W-1:0] xpt,
    input  z80_ctrl_pkg::stack_op_e        op,
    input  logic                           is_y,
    output logic                           sel_sp_addr,
    output logic                           mem_wr,
    output logic                           sp_inc,
    output logic                           sp_dec,
    output logic                           wr_x_low,
    output logic                           wr_x_high,
    output logic                           rd_x_low,
    output logic                           rd_x_high,
    output logic                           xpt_reset
);

    localparam int XW  = z80_ctrl_pkg::XPT_W;
    localparam int N_T = int'(z80_ctrl_pkg::XPT_LAST) - int'(z80_ctrl_pkg::XPT_FIRST) + 1;

    logic [N_T-1:0] t; // t[0] is t4
    logic           t4, t5, t6, t7, t8, t9;
    logic           c0, c1, c2;
    logic           is_push;

    for (genvar g = 0; g < N_T; g++) begin : g_onehot
        assign t[g] = enable && (xpt == XW'(int'(z80_ctrl_pkg::XPT_FIRST) + g));
    end

    assign t4 = t[0];
    assign t5 = t[1];
    assign t6 = t[2];
    assign t7 = t[3];
    assign t8 = t[4];
    assign t9 = t[5];

    assign is_push = (op == z80_ctrl_pkg::op_push);

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // cycle strobes
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    assign sel_sp_addr = |t; // sp drives the address for t4..t9
    assign c0 = t4 | t7;     // push: step sp down
    assign c1 = t5 | t8;     // push: byte out
    assign c2 = t6 | t9;     // pop: byte in, step sp up

    assign sp_dec    = is_push && c0;
    assign mem_wr    = is_push && c1;
    assign sp_inc    = !is_push && c2;
    assign xpt_reset = t9;

    // byte role only, the datapath picks ix or iy
    assign wr_x_low  = !is_push && t6;
    assign wr_x_high = !is_push && t9;
    assign rd_x_high = is_push && t5; // high byte goes out first
    assign rd_x_low  = is_push && t8;

endmodule

// ==== hw/xpt_sequencer.sv ====
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// command pop, xpt counter and busy flag
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps

module xpt_sequencer (
    input  logic                            clk,
    input  logic                            rst,
    input  logic                            empty,
    input  logic [z80_bus_pkg::CMD_W-1:0]   pop_data,
    input  logic                            xpt_reset,
    output logic                            pop,
    output logic [z80_ctrl_pkg::XPT_W-1:0]  xpt,
    output logic                            enable,
    output z80_ctrl_pkg::stack_op_e         op,
    output logic                            is_y,
    output logic                            busy
);

    z80_ctrl_pkg::seq_state_e state;

    assign pop    = (state == z80_ctrl_pkg::st_idle) && !empty;
    assign enable = (state == z80_ctrl_pkg::st_exec);
    assign busy   = (state != z80_ctrl_pkg::st_idle); // load through t9

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // control fsm and xpt count
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    always_ff @(posedge clk) begin
        if (rst) begin
            state <= z80_ctrl_pkg::st_idle;
            xpt   <= '0;
        end else begin
            case (state)
                z80_ctrl_pkg::st_idle: begin
                    if (pop) begin
                        state <= z80_ctrl_pkg::st_load;
                    end
                end
                z80_ctrl_pkg::st_load: begin
                    xpt   <= z80_ctrl_pkg::XPT_FIRST;
                    state <= z80_ctrl_pkg::st_exec;
                end
                z80_ctrl_pkg::st_exec: begin
                    if (xpt_reset) begin // decoder ends the op at t9
                        xpt   <= '0;
                        state <= z80_ctrl_pkg::st_idle;
                    end else begin
                        xpt <= xpt + 1'b1;
                    end
                end
                default: state <= z80_ctrl_pkg::st_idle;
            endcase
        end
    end

    // latched instruction
    always_ff @(posedge clk) begin
        if (pop) begin
            op   <= z80_ctrl_pkg::stack_op_e'(pop_data[z80_bus_pkg::CMD_BIT_PUSH]);
            is_y <= pop_data[z80_bus_pkg::CMD_BIT_IS_Y];
        end
    end

    a_xpt_range: assert property (@(posedge clk) disable iff (rst)
        enable |-> (xpt >= z80_ctrl_pkg::XPT_FIRST) && (xpt <= z80_ctrl_pkg::XPT_LAST));

endmodule

// ==== hw/z80_bus_pkg.sv ====
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// apb register map, command word and status layout
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
package z80_bus_pkg;

    // register offsets
    localparam logic [4:0] ADDR_CMD    = 5'h00;
    localparam logic [4:0] ADDR_IX     = 5'h04;
    localparam logic [4:0] ADDR_IY     = 5'h08;
    localparam logic [4:0] ADDR_SP     = 5'h0C;
    localparam logic [4:0] ADDR_STATUS = 5'h10;

    // command word
    localparam int CMD_W        = 2;
    localparam int CMD_BIT_IS_Y = 0; // 1 selects iy
    localparam int CMD_BIT_PUSH = 1; // 1 push, 0 pop

    // status word
    localparam int STAT_CNT_W    = 8; // fifo count in the low bits
    localparam int STAT_BIT_BUSY = 8;

endpackage

// ==== hw/z80_ctrl_pkg.sv ====
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// sequencer state, stack opcode and xpt constants
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
package z80_ctrl_pkg;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // control encodings
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    typedef enum logic [1:0] {
        st_idle = 2'd0, // waiting for a queued command
        st_load = 2'd1, // command latched, xpt about to start
        st_exec = 2'd2  // xpt stepping through the stack cycles
    } seq_state_e;

    typedef enum logic {
        op_pop  = 1'b0, // pop ix/iy
        op_push = 1'b1  // push ix/iy
    } stack_op_e;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // timing states
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    localparam int XPT_W = 5;

    // t1..t3 belong to the opcode fetch, which is not modelled here
    localparam logic [XPT_W-1:0] XPT_FIRST = 5'd4;
    localparam logic [XPT_W-1:0] XPT_LAST  = 5'd9;

endpackage

// ==== verif/stack_engine_tb.sv ====
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// testbench for the stack engine: apb tasks, lfsr stimulus,
// stack model, concurrent checks, watchdog and summary
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps

module stack_engine_tb;

    localparam int FIFO_DEPTH   = 4;
    localparam int ROUNDS       = 4;
    localparam int ROUND_CMDS   = 8;
    localparam int BURST_CMDS   = 2 * FIFO_DEPTH; // enough to overrun the fifo
    localparam int N_CMDS       = 2 + ROUNDS * ROUND_CMDS + BURST_CMDS;
    localparam int WATCHDOG_CYC = N_CMDS * 20 + 600;
    localparam int XFER_LIMIT   = 200;
    localparam logic [15:0] LFSR_TAPS = 16'hB400;

    logic        clk, rst, psel, penable, pwrite, pslverr, pready;
    logic [4:0]  paddr;
    logic [15:0] pwdata, prdata;

    logic [15:0] lfsr = 16'd62;
    logic [15:0] m_ix, m_iy, m_sp; // reference model registers
    logic [15:0] stack_q[$];       // reference model stack, top at the back
    logic        exp_on, exp_err, runs_chk, stall_chk, xfer_done;
    logic [15:0] exp_data;
    string       exp_name;
    int          errors, cmd_cnt, exec_cnt, stall_cnt, n_push, n_pop;

    stack_engine_top #(.FIFO_DEPTH(FIFO_DEPTH), .STACK_AW(8)) dut0 (
        .clk, .rst, .psel, .penable, .pwrite, .paddr, .pwdata,
        .prdata, .pready, .pslverr
    );

    always #2 clk = ~clk;

    assign xfer_done = psel && penable && pready;

    always @(posedge clk) begin
        if (rst) begin
            exec_cnt <= 0;
        end else if (dut0.xpt_reset) begin
            exec_cnt <= exec_cnt + 1; // one t9 per executed instruction
        end
    end

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // checks
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    a_rdata: assert property (@(posedge clk) disable iff (rst)
        (xfer_done && !pwrite && exp_on) |-> (prdata == exp_data))
        else begin
            errors++;
            $display("mismatch at %0t: %s got %h expected %h",
                     $time, exp_name, $sampled(prdata), exp_data);
        end

    a_slverr: assert property (@(posedge clk) disable iff (rst)
        xfer_done |-> (pslverr == exp_err))
        else begin
            errors++;
            $display("mismatch at %0t: pslverr got %b expected %b",
                     $time, $sampled(pslverr), exp_err);
        end

    a_full_wait: assert property (@(posedge clk) disable iff (rst)
        (psel && penable && pwrite && paddr == z80_bus_pkg::ADDR_CMD && dut0.full) |-> !pready)
        else begin
            errors++;
            $display("command write at %0t completed while the fifo was full", $time);
        end

    a_runs: assert property (@(posedge clk) disable iff (rst)
        runs_chk |-> (exec_cnt == cmd_cnt))
        else begin
            errors++;
            $display("mismatch at %0t: exec_count got %0d expected %0d", $time, exec_cnt, cmd_cnt);
        end

    a_stall: assert property (@(posedge clk) disable iff (rst)
        stall_chk |-> (stall_cnt > 0))
        else begin
            errors++;
            $display("no wait state was seen while queuing past the fifo depth");
        end

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // stimulus helpers
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    function automatic logic [15:0] lfsr_step(input logic [15:0] s);
        lfsr_step = s[0] ? ((s >> 1) ^ LFSR_TAPS) : (s >> 1);
    endfunction

    task automatic take_bits(input int n, output logic [15:0] v);
        v = '0;
        for (int i = 0; i < n; i++) begin
            v = {v[14:0], lfsr[0]};
            lfsr = lfsr_step(lfsr);
        end
    endtask

    // called 0.5 ns after an edge, returns 0.5 ns after the completing edge
    task automatic apb_xfer(input logic wr, input logic [4:0] addr, input logic [15:0] data,
                            output logic [15:0] rdata);
        int waits;
        psel = 1'b1;
        penable = 1'b0;
        pwrite = wr;
        paddr = addr;
        pwdata = data;
        @(posedge clk);
        #0.5;
        penable = 1'b1;
        waits = 0;
        @(negedge clk);
        while (!pready && waits < XFER_LIMIT) begin
            if (wr && addr == z80_bus_pkg::ADDR_CMD) begin
                stall_cnt++;
            end
            waits++;
            @(negedge clk);
        end
        if (!pready) begin
            errors++;
            $display("apb transfer to address %h never got pready", addr);
        end
        rdata = prdata;
        @(posedge clk);
        #0.5;
        psel = 1'b0;
        penable = 1'b0;
        pwrite = 1'b0;
    endtask

    task automatic apb_write(input logic [4:0] addr, input logic [15:0] data);
        logic [15:0] unused;
        apb_xfer(1'b1, addr, data, unused);
    endtask

    task automatic apb_read(input logic [4:0] addr, output logic [15:0] data);
        apb_xfer(1'b0, addr, 16'h0000, data);
    endtask

    task automatic check_reg(input logic [4:0] addr, input logic [15:0] expv, input string name);
        logic [15:0] got;
        exp_on = 1'b1;
        exp_data = expv;
        exp_name = name;
        apb_read(addr, got);
        exp_on = 1'b0;
    endtask

    task automatic check_model_regs();
        check_reg(z80_bus_pkg::ADDR_IX, m_ix, "ix");
        check_reg(z80_bus_pkg::ADDR_IY, m_iy, "iy");
        check_reg(z80_bus_pkg::ADDR_SP, m_sp, "sp");
    endtask

    // poll status until the fifo is empty and the engine idle
    task automatic drain();
        logic [15:0] st;
        int polls;
        polls = 0;
        st = 16'hFFFF;
        while (st != 16'h0000 && polls < XFER_LIMIT) begin
            apb_read(z80_bus_pkg::ADDR_STATUS, st);
            polls++;
        end
        if (st != 16'h0000) begin
            errors++;
            $display("engine did not go idle, status stuck at %h", st);
        end
    endtask

    task automatic set_regs();
        logic [15:0] v;
        take_bits(16, v);
        apb_write(z80_bus_pkg::ADDR_IX, v);
        m_ix = v;
        take_bits(16, v);
        apb_write(z80_bus_pkg::ADDR_IY, v);
        m_iy = v;
    endtask

    task automatic issue_cmd(input logic push_op, input logic use_y);
        logic [15:0] cmd;
        logic [15:0] v;
        cmd = '0;
        cmd[z80_bus_pkg::CMD_BIT_PUSH] = push_op;
        cmd[z80_bus_pkg::CMD_BIT_IS_Y] = use_y;
        if (push_op) begin
            stack_q.push_back(use_y ? m_iy : m_ix);
            m_sp = m_sp - 16'd2;
            n_push++;
        end else begin
            v = stack_q.pop_back();
            if (use_y) begin
                m_iy = v;
            end else begin
                m_ix = v;
            end
            m_sp = m_sp + 16'd2;
            n_pop++;
        end
        apb_write(z80_bus_pkg::ADDR_CMD, cmd);
        cmd_cnt++;
    endtask

    task automatic random_cmds(input int n);
        logic [15:0] r;
        for (int i = 0; i < n; i++) begin
            take_bits(2, r);
            issue_cmd(r[1] || (stack_q.size() == 0), r[0]); // never pop an empty model
        end
    endtask

    task automatic pulse_checks(input logic with_stall);
        runs_chk = 1'b1;
        stall_chk = with_stall;
        @(posedge clk);
        #0.5;
        runs_chk = 1'b0;
        stall_chk = 1'b0;
    endtask

    initial begin
        #(WATCHDOG_CYC * 4);
        $display("watchdog expired after %0d cycles, the run did not finish", WATCHDOG_CYC);
        $display(">>> FAIL");
        $finish;
    end

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // test sequence
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    initial begin
        logic [15:0] v;
        logic [15:0] sp0;
        clk = 1'b0;
        rst = 1'b1;
        {psel, penable, pwrite, paddr, pwdata} = '0;
        {exp_on, exp_err, runs_chk, stall_chk, exp_data} = '0;
        exp_name = "";
        errors = 0;
        cmd_cnt = 0;
        stall_cnt = 0;
        n_push = 0;
        n_pop = 0;
        m_ix = 16'h0000;
        m_iy = 16'h0000;
        m_sp = 16'hFFFF;
        repeat (2) @(posedge clk);
        #0.5;
        rst = 1'b0;

        check_model_regs(); // reset values
        check_reg(z80_bus_pkg::ADDR_STATUS, 16'h0000, "status");

        take_bits(16, v); // push ix then pop iy
        apb_write(z80_bus_pkg::ADDR_IX, v);
        m_ix = v;
        issue_cmd(1'b1, 1'b0);
        issue_cmd(1'b0, 1'b1);
        drain();
        check_reg(z80_bus_pkg::ADDR_IY, v, "iy");
        check_reg(z80_bus_pkg::ADDR_SP, m_sp, "sp");

        for (int r = 0; r < ROUNDS; r++) begin
            set_regs();
            sp0 = m_sp;
            n_push = 0;
            n_pop = 0;
            random_cmds(ROUND_CMDS);
            drain();
            check_reg(z80_bus_pkg::ADDR_IX, m_ix, "ix");
            check_reg(z80_bus_pkg::ADDR_IY, m_iy, "iy");
            check_reg(z80_bus_pkg::ADDR_SP, sp0 - 16'(2 * n_push) + 16'(2 * n_pop), "sp");
        end

        set_regs(); // burst past the fifo depth
        stall_cnt = 0;
        random_cmds(BURST_CMDS);
        drain();
        pulse_checks(1'b1);
        check_model_regs();

        exp_err = 1'b1; // unmapped offsets
        apb_write(5'h14, 16'hA5A5);
        apb_read(5'h1C, v);
        exp_err = 1'b0;
        check_model_regs();

        pulse_checks(1'b0);
        @(posedge clk);
        $display("summary: %0d commands, %0d executed, %0d errors", cmd_cnt, exec_cnt, errors);
        if (errors == 0) begin
            $display(">>> PASS");
        end else begin
            $display(">>> FAIL");
        end
        $finish;
    end

endmodule
